/* Makefile */
TOP := fetch_unit_tb

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run the testbench, check sim.log"
	@echo "make clean  remove obj_dir and sim.log"
	@echo "make help   show this list"

test:
	verilator --binary --timing -f fetch_unit.f --top-module $(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1 || (cat sim.log; exit 1)
	@cat sim.log
	@if grep -q "TB FAILED" sim.log; then echo "simulation reported failure"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf obj_dir sim.log

/* fetch_unit.f */
+incdir+logic
logic/fetch_pkg.sv
logic/insn_mem.sv
logic/gpr_file.sv
logic/jump_operand_fwd.sv
logic/branch_predictor.sv
logic/pc_gen.sv
logic/fetch_unit.sv
tb/fetch_unit_tb.sv

/* logic/branch_predictor.sv */
`timescale 1ns/1ps
`include "fetch_params.svh"

module branch_predictor (
    input  logic [`PC_WIDTH-1:0]            pc,
    input  logic [`WORD_WIDTH-1:0]          insn,
    input  logic [`WORD_WIDTH-1:0]          gpr_rd_data,
    input  logic [`WORD_WIDTH-1:0]          gpr_x1,
    input  fetch_pkg::gpr_wr_t              gpr_wr,
    input  fetch_pkg::pipe_hazard_t         hazard,
    input  fetch_pkg::fwd_data_t            fwd,
    output logic [`GPR_ADDR_WIDTH-1:0]      predt_gpr_rd_addr,
    output logic                            predt_br_taken,
    output logic [`PC_WIDTH-1:0]            predt_pc
);

    import fetch_pkg::*;

    logic [6:0]                     opcode;
    logic                           is_jal;
    logic                           is_jalr;
    logic                           is_branch;
    logic [`GPR_ADDR_WIDTH-1:0]     rs1;
    logic [`WORD_WIDTH-1:0]         x1_value;
    logic                           x1_valid;
    logic [`WORD_WIDTH-1:0]         rs1_value;
    logic                           rs1_valid;
    logic [`WORD_WIDTH-1:0]         imm;
    jump_base_e                     base_sel;
    logic [`WORD_WIDTH-1:0]         base;
    logic                           base_valid;

    assign opcode    = insn[`ALL_TYPE_OPCODE];
    assign is_jal    = (opcode == `OP_JAL);
    assign is_jalr   = (opcode == `OP_JALR);
    assign is_branch = (opcode == `OP_BRANCH);

    assign rs1               = insn[`I_TYPE_RS1];
    assign predt_gpr_rd_addr = rs1;

    jump_operand_fwd x1_fwd_i (
        .idx    (`GPR_ADDR_WIDTH'd1),
        .stored (gpr_x1),
        .gpr_wr (gpr_wr),
        .hazard (hazard),
        .fwd    (fwd),
        .value  (x1_value),
        .valid  (x1_valid)
    );

    jump_operand_fwd rs1_fwd_i (
        .idx    (rs1),
        .stored (gpr_rd_data),
        .gpr_wr (gpr_wr),
        .hazard (hazard),
        .fwd    (fwd),
        .value  (rs1_value),
        .valid  (rs1_valid)
    );

    always_comb begin
        if (is_jal) begin
            imm = {{12{insn[`J_TYPE_IMM_20]}}, insn[`J_TYPE_IMM_19_12],
                   insn[`J_TYPE_IMM_11], insn[`J_TYPE_IMM_10_1], 1'b0};
        end else if (is_branch) begin
            imm = {{20{insn[`B_TYPE_IMM_12]}}, insn[`B_TYPE_IMM_11],
                   insn[`B_TYPE_IMM_10_5], insn[`B_TYPE_IMM_4_1], 1'b0};
        end else begin
            imm = {{20{insn[`INSN_MSB]}}, insn[`I_TYPE_IMM]};   // jalr, others don't care
        end
    end

    always_comb begin
        if (!is_jalr) begin
            base_sel = BASE_PC;
        end else if (rs1 == '0) begin
            base_sel = BASE_ZERO;
        end else if (rs1 == `GPR_ADDR_WIDTH'd1) begin
            base_sel = BASE_X1;                 // typical return
        end else begin
            base_sel = BASE_RS1;
        end
    end

    always_comb begin
        case (base_sel)
            BASE_ZERO: begin
                base       = '0;
                base_valid = 1'b1;
            end
            BASE_X1: begin
                base       = x1_value;
                base_valid = x1_valid;
            end
            BASE_RS1: begin
                base       = rs1_value;
                base_valid = rs1_valid;
            end
            default: begin
                base       = pc;
                base_valid = 1'b0;              // only matters for jalr
            end
        endcase
    end

    assign predt_br_taken = is_jal
                         || (is_branch && insn[`B_TYPE_IMM_12])    // backward branch
                         || (is_jalr && base_valid);

    assign predt_pc = base + imm;

endmodule

/* logic/fetch_params.svh */
`ifndef FETCH_PARAMS_SVH
`define FETCH_PARAMS_SVH

`define PC_WIDTH            32
`define WORD_WIDTH          32
`define GPR_ADDR_WIDTH      5
`define IMEM_DEPTH          256
`define IMEM_ADDR_WIDTH     8

`define OP_JAL              7'b1101111
`define OP_JALR             7'b1100111
`define OP_BRANCH           7'b1100011

`define INSN_MSB            31
`define ALL_TYPE_OPCODE     6:0

`define I_TYPE_RS1          19:15
`define I_TYPE_IMM          31:20

`define J_TYPE_IMM_20       31
`define J_TYPE_IMM_10_1     30:21
`define J_TYPE_IMM_11       20
`define J_TYPE_IMM_19_12    19:12

`define B_TYPE_IMM_12       31
`define B_TYPE_IMM_10_5     30:25
`define B_TYPE_IMM_4_1      11:8
`define B_TYPE_IMM_11       7

`endif

/* logic/fetch_pkg.sv */
`include "fetch_params.svh"

package fetch_pkg;

    typedef struct packed {
        logic                           taken;
        logic [`PC_WIDTH-1:0]           addr;
    } redirect_t;

    typedef struct packed {
        logic                           trap_happened;
        logic                           mret_en;
        logic [`PC_WIDTH-1:0]           ctrl_pc;
    } trap_ctrl_t;

    typedef struct packed {
        logic                           we;     // active high
        logic [`GPR_ADDR_WIDTH-1:0]     addr;
        logic [`WORD_WIDTH-1:0]         data;
    } gpr_wr_t;

    typedef struct packed {
        logic                           alu2gpr_in_id_ex;
        logic                           alu2gpr_in_ex_mem;
        logic                           load_in_id_ex;
        logic                           load_in_ex_mem;
        logic                           load_after_storing_en;
        logic                           loading_after_store_en;
        logic [`GPR_ADDR_WIDTH-1:0]     id_dst_addr;
        logic [`GPR_ADDR_WIDTH-1:0]     ex_dst_addr;
    } pipe_hazard_t;

    typedef struct packed {
        logic [`WORD_WIDTH-1:0]         alu_out;
        logic [`WORD_WIDTH-1:0]         ex_alu_out;
        logic [`WORD_WIDTH-1:0]         ex_store_data;
        logic [`WORD_WIDTH-1:0]         prev_ex_store_data;
    } fwd_data_t;

    typedef struct packed {
        logic                           we;
        logic [`IMEM_ADDR_WIDTH-1:0]    addr;   // word index
        logic [`WORD_WIDTH-1:0]         data;
    } imem_wr_t;

    // adder base for the predicted target
    typedef enum logic [1:0] {
        BASE_PC,
        BASE_ZERO,
        BASE_X1,
        BASE_RS1
    } jump_base_e;

endpackage

/* logic/fetch_unit.sv */
`timescale 1ns/1ps
`include "fetch_params.svh"

module fetch_unit (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        cpu_en,
    input  logic                        pc_stall,
    input  fetch_pkg::redirect_t        redirect,
    input  fetch_pkg::trap_ctrl_t       trap_ctrl,
    input  fetch_pkg::gpr_wr_t          gpr_wr,
    input  fetch_pkg::pipe_hazard_t     hazard,
    input  fetch_pkg::fwd_data_t        fwd,
    input  fetch_pkg::imem_wr_t         imem_wr,
    output logic [`PC_WIDTH-1:0]        pc,
    output logic [`WORD_WIDTH-1:0]      insn,
    output logic                        predt_br_taken
);

    logic [`GPR_ADDR_WIDTH-1:0]     predt_gpr_rd_addr;
    logic [`WORD_WIDTH-1:0]         gpr_rd_data;
    logic [`WORD_WIDTH-1:0]         gpr_x1;
    logic [`PC_WIDTH-1:0]           predt_pc;

    insn_mem insn_mem_i (
        .clk        (clk),
        .imem_wr    (imem_wr),
        .pc         (pc),
        .insn       (insn)
    );

    gpr_file gpr_file_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .gpr_wr     (gpr_wr),
        .rd_addr    (predt_gpr_rd_addr),
        .rd_data    (gpr_rd_data),
        .gpr_x1     (gpr_x1)
    );

    branch_predictor branch_predictor_i (
        .pc                 (pc),
        .insn               (insn),
        .gpr_rd_data        (gpr_rd_data),
        .gpr_x1             (gpr_x1),
        .gpr_wr             (gpr_wr),
        .hazard             (hazard),
        .fwd                (fwd),
        .predt_gpr_rd_addr  (predt_gpr_rd_addr),
        .predt_br_taken     (predt_br_taken),
        .predt_pc           (predt_pc)
    );

    pc_gen pc_gen_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .cpu_en         (cpu_en),
        .pc_stall       (pc_stall),
        .trap_ctrl      (trap_ctrl),
        .redirect       (redirect),
        .predt_br_taken (predt_br_taken),
        .predt_pc       (predt_pc),
        .pc             (pc)
    );

endmodule

/* logic/gpr_file.sv */
`timescale 1ns/1ps
`include "fetch_params.svh"

module gpr_file (
    input  logic                            clk,
    input  logic                            rst_n,
    input  fetch_pkg::gpr_wr_t              gpr_wr,
    input  logic [`GPR_ADDR_WIDTH-1:0]      rd_addr,
    output logic [`WORD_WIDTH-1:0]          rd_data,
    output logic [`WORD_WIDTH-1:0]          gpr_x1
);

    logic [`WORD_WIDTH-1:0] regs [2**`GPR_ADDR_WIDTH];
    logic                   wr_en;

    assign wr_en = gpr_wr.we && (gpr_wr.addr != '0);    // x0 stays zero

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 2**`GPR_ADDR_WIDTH; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[gpr_wr.addr] <= gpr_wr.data;
        end
    end

    assign rd_data = regs[rd_addr];             // predictor port
    assign gpr_x1  = regs[`GPR_ADDR_WIDTH'd1];  // return address tap

endmodule

/* logic/insn_mem.sv */
`timescale 1ns/1ps
`include "fetch_params.svh"

module insn_mem (
    input  logic                        clk,
    input  fetch_pkg::imem_wr_t         imem_wr,
    input  logic [`PC_WIDTH-1:0]        pc,
    output logic [`WORD_WIDTH-1:0]      insn
);

    logic [`WORD_WIDTH-1:0]         mem [`IMEM_DEPTH];
    logic [`IMEM_ADDR_WIDTH-1:0]    rd_idx;

    assign rd_idx = pc[`IMEM_ADDR_WIDTH+1:2];   // word address from pc

    always_ff @(posedge clk) begin
        if (imem_wr.we) begin
            mem[imem_wr.addr] <= imem_wr.data;  // loader port
        end
    end

    // no read latency, fetch sees the word in the same cycle
    assign insn = mem[rd_idx];

endmodule

/* logic/jump_operand_fwd.sv */
`timescale 1ns/1ps
`include "fetch_params.svh"

module jump_operand_fwd (
    input  logic [`GPR_ADDR_WIDTH-1:0]      idx,
    input  logic [`WORD_WIDTH-1:0]          stored,
    input  fetch_pkg::gpr_wr_t              gpr_wr,
    input  fetch_pkg::pipe_hazard_t         hazard,
    input  fetch_pkg::fwd_data_t            fwd,
    output logic [`WORD_WIDTH-1:0]          value,
    output logic                            valid
);

    logic id_hit;
    logic ex_hit;
    logic wb_busy;
    logic id_load_stall;
    logic ex_load_stall;

    assign id_hit = (hazard.id_dst_addr == idx);
    assign ex_hit = (hazard.ex_dst_addr == idx);

    always_comb begin
        if (hazard.alu2gpr_in_id_ex && id_hit) begin
            value = fwd.alu_out;                // result leaving the alu now
        end else if (hazard.alu2gpr_in_ex_mem && ex_hit) begin
            value = fwd.ex_alu_out;
        end else if (hazard.load_in_id_ex && id_hit && hazard.load_after_storing_en) begin
            value = fwd.ex_store_data;          // load hits the store just ahead
        end else if (hazard.load_in_ex_mem && ex_hit && hazard.loading_after_store_en) begin
            value = fwd.prev_ex_store_data;
        end else begin
            value = stored;
        end
    end

    assign wb_busy       = gpr_wr.we && (gpr_wr.addr == idx);
    assign id_load_stall = hazard.load_in_id_ex && id_hit && !hazard.load_after_storing_en;

    // The ex/mem load case is treated as unusable even though a forward
    // path exists above. The later pipeline expects fetch to hold off here.
    assign ex_load_stall = hazard.load_in_ex_mem && ex_hit && hazard.loading_after_store_en;

    assign valid = !wb_busy && !id_load_stall && !ex_load_stall;

endmodule

/* logic/pc_gen.sv */
`timescale 1ns/1ps
`include "fetch_params.svh"

module pc_gen (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        cpu_en,
    input  logic                        pc_stall,
    input  fetch_pkg::trap_ctrl_t       trap_ctrl,
    input  fetch_pkg::redirect_t        redirect,
    input  logic                        predt_br_taken,
    input  logic [`PC_WIDTH-1:0]        predt_pc,
    output logic [`PC_WIDTH-1:0]        pc
);

    logic ctrl_redirect;

    assign ctrl_redirect = trap_ctrl.trap_happened || trap_ctrl.mret_en;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= '0;
        end else if (cpu_en) begin
            if (ctrl_redirect) begin
                pc <= trap_ctrl.ctrl_pc;        // wins even over a stall
            end else if (!pc_stall) begin
                if (redirect.taken) begin
                    pc <= redirect.addr;        // execute corrects the guess
                end else if (predt_br_taken) begin
                    pc <= predt_pc;
                end else begin
                    pc <= pc + `PC_WIDTH'd4;
                end
            end
        end
    end

endmodule

/* tb/fetch_unit_tb.sv */
`timescale 1ns/1ps
`include "fetch_params.svh"

module fetch_unit_tb;

    import fetch_pkg::*;

    localparam int CLK_PERIOD   = 8;
    // reset, memory fill, then the five tests
    localparam int CYCLE_BUDGET = 5 + 256 + 12 + 13 + 11 + 10 + 8;

    logic           clk;
    logic           rst_n;
    logic           cpu_en;
    logic           pc_stall;
    redirect_t      redirect;
    trap_ctrl_t     trap_ctrl;
    gpr_wr_t        gpr_wr;
    pipe_hazard_t   hazard;
    fwd_data_t      fwd;
    imem_wr_t       imem_wr;
    logic [31:0]    pc;
    logic [31:0]    insn;
    logic           predt_br_taken;

    logic [31:0]    ref_mem [256];
    logic [31:0]    ref_regs [32];
    logic [31:0]    exp_pc;
    logic [31:0]    lfsr = 32'd7;
    int             n_checks;
    int             n_errors;

    fetch_unit dut_i (.*);

    always #(CLK_PERIOD/2) clk = ~clk;

    function automatic logic next_bit();
        logic b;
        b    = lfsr[0];
        lfsr = b ? ((lfsr >> 1) ^ 32'hA300_0000) : (lfsr >> 1);   // galois step
        return b;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], next_bit()};
        end
        return r;
    endfunction

    function automatic logic [31:0] enc_jal(input logic [4:0] rd, input logic [31:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, `OP_JAL};
    endfunction

    function automatic logic [31:0] enc_jalr(input logic [4:0] rd, input logic [4:0] rs1,
                                             input logic [31:0] imm);
        return {imm[11:0], rs1, 3'b000, rd, `OP_JALR};
    endfunction

    // beq rs1, x3
    function automatic logic [31:0] enc_branch(input logic [4:0] rs1, input logic [31:0] imm);
        return {imm[12], imm[10:5], 5'd3, rs1, 3'b000, imm[4:1], imm[11], `OP_BRANCH};
    endfunction

    function automatic logic [31:0] enc_addi(input logic [4:0] rd, input logic [31:0] imm);
        return {imm[11:0], 5'd0, 3'b000, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] random_jal();
        logic [31:0] r;
        r = rand_bits(20);
        return enc_jal(5'd1, {{11{r[19]}}, r[19:0], 1'b0});
    endfunction

    function automatic logic [31:0] random_jalr(input logic [4:0] rs1);
        logic [31:0] r;
        r = rand_bits(12);
        return enc_jalr(5'd0, rs1, {{20{r[11]}}, r[11:0]});
    endfunction

    // jalr base for a non-zero index with the usable flag in bit 32
    function automatic logic [32:0] jalr_base(input logic [4:0] idx);
        logic        id_hit;
        logic        ex_hit;
        logic        usable;
        logic [31:0] value;
        id_hit = (hazard.id_dst_addr == idx);
        ex_hit = (hazard.ex_dst_addr == idx);
        usable = !(gpr_wr.we && gpr_wr.addr == idx)
              && !(hazard.load_in_id_ex && id_hit && !hazard.load_after_storing_en)
              && !(hazard.load_in_ex_mem && ex_hit && hazard.loading_after_store_en);
        if (hazard.alu2gpr_in_id_ex && id_hit) begin
            value = fwd.alu_out;
        end else if (hazard.alu2gpr_in_ex_mem && ex_hit) begin
            value = fwd.ex_alu_out;
        end else if (hazard.load_in_id_ex && id_hit && hazard.load_after_storing_en) begin
            value = fwd.ex_store_data;
        end else begin
            value = ref_regs[idx];  // ex/mem load case is never usable
        end
        return {usable, value};
    endfunction

    function automatic logic [32:0] predict(input logic [31:0] at_pc, input logic [31:0] w);
        logic [31:0] j_imm;
        logic [31:0] b_imm;
        logic [31:0] i_imm;
        logic [32:0] base;
        j_imm = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
        b_imm = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        i_imm = {{20{w[31]}}, w[31:20]};
        base  = (w[19:15] == 5'd0) ? {1'b1, 32'd0} : jalr_base(w[19:15]);
        case (w[6:0])
            `OP_JAL:    return {1'b1, at_pc + j_imm};
            `OP_BRANCH: return {w[31], at_pc + b_imm};     // backward taken
            `OP_JALR:   return {base[32], base[31:0] + i_imm};
            default:    return {1'b0, at_pc + 32'd4};
        endcase
    endfunction

    function automatic logic [31:0] next_pc(input logic [31:0] at_pc, input logic [31:0] w);
        logic [32:0] p;
        p = predict(at_pc, w);
        if (!cpu_en) begin
            return at_pc;
        end else if (trap_ctrl.trap_happened || trap_ctrl.mret_en) begin
            return trap_ctrl.ctrl_pc;
        end else if (pc_stall) begin
            return at_pc;
        end else if (redirect.taken) begin
            return redirect.addr;
        end
        return p[32] ? p[31:0] : at_pc + 32'd4;
    endfunction

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        n_checks++;
        if (actual !== expected) begin
            n_errors++;
            $display("mismatch %s: got %h, expected %h at %0t", name, actual, expected, $time);
        end
    endtask

    task automatic end_test(input string name, input int errs_before);
        $display("%s: %0d mismatches", name, n_errors - errs_before);
    endtask

    // inputs set at the falling edge and outputs sampled 1 ns later
    task automatic fetch_cycle();
        logic [32:0] p;
        #1;
        p = predict(exp_pc, ref_mem[exp_pc[9:2]]);
        check("pc", pc, exp_pc);
        check("insn", insn, ref_mem[exp_pc[9:2]]);
        check("predt_br_taken", {31'd0, predt_br_taken}, {31'd0, p[32]});
        exp_pc = next_pc(exp_pc, ref_mem[exp_pc[9:2]]);
        if (gpr_wr.we && gpr_wr.addr != 5'd0) begin
            ref_regs[gpr_wr.addr] = gpr_wr.data;
        end
        @(negedge clk);
    endtask

    task automatic write_imem(input logic [7:0] addr, input logic [31:0] data);
        cpu_en       = 1'b0;        // pc holds while loading
        imem_wr.we   = 1'b1;
        imem_wr.addr = addr;
        imem_wr.data = data;
        @(negedge clk);
        ref_mem[addr] = data;
        imem_wr.we    = 1'b0;
    endtask

    task automatic reset_and_sequential();
        int errs;
        errs = n_errors;
        check("pc", pc, 32'd0);
        for (int i = 0; i < 256; i++) begin
            write_imem(i[7:0], enc_addi(i[4:0], {24'd0, i[7:0]}));
        end
        fetch_cycle();
        cpu_en = 1'b1;
        repeat (6) fetch_cycle();
        cpu_en = 1'b0;
        repeat (2) fetch_cycle();
        cpu_en   = 1'b1;
        pc_stall = 1'b1;
        repeat (2) fetch_cycle();
        pc_stall = 1'b0;
        fetch_cycle();
        end_test("reset and sequential fetch", errs);
    endtask

    task automatic jal_and_branches();
        int          errs;
        logic [31:0] r;
        errs = n_errors;
        repeat (4) begin
            write_imem(exp_pc[9:2], random_jal());
            cpu_en = 1'b1;
            fetch_cycle();
        end
        r = rand_bits(11);
        write_imem(exp_pc[9:2], enc_branch(5'd2, {19'h7ffff, 1'b1, r[10:0], 1'b0}));
        cpu_en = 1'b1;
        fetch_cycle();
        r = rand_bits(11);
        write_imem(exp_pc[9:2], enc_branch(5'd2, {20'd0, r[10:0], 1'b0}));
        cpu_en = 1'b1;
        fetch_cycle();
        fetch_cycle();
        end_test("jal and branches", errs);
    endtask

    task automatic jalr_bases();
        int errs;
        errs = n_errors;
        write_imem(exp_pc[9:2], random_jalr(5'd0));
        cpu_en = 1'b1;
        fetch_cycle();
        for (int k = 0; k < 2; k++) begin
            gpr_wr.we   = 1'b1;
            gpr_wr.addr = (k == 0) ? 5'd1 : 5'd5;
            gpr_wr.data = rand_bits(32);
            cpu_en      = 1'b0;
            fetch_cycle();
        end
        gpr_wr = '0;
        write_imem(exp_pc[9:2], random_jalr(5'd1));
        cpu_en = 1'b1;
        fetch_cycle();
        write_imem(exp_pc[9:2], random_jalr(5'd5));
        cpu_en = 1'b1;
        fetch_cycle();
        write_imem(exp_pc[9:2], random_jalr(5'd5));
        gpr_wr.we   = 1'b1;         // x5 written in the same cycle
        gpr_wr.addr = 5'd5;
        gpr_wr.data = rand_bits(32);
        cpu_en      = 1'b1;
        fetch_cycle();
        gpr_wr = '0;
        fetch_cycle();
        end_test("jalr bases", errs);
    endtask

    task automatic jalr_forwarding();
        int errs;
        errs = n_errors;
        gpr_wr.we   = 1'b1;
        gpr_wr.addr = 5'd6;
        gpr_wr.data = rand_bits(32);
        cpu_en      = 1'b0;
        fetch_cycle();
        gpr_wr = '0;
        for (int k = 0; k < 4; k++) begin
            write_imem(exp_pc[9:2], random_jalr(5'd6));
            fwd.alu_out            = rand_bits(32);
            fwd.ex_alu_out         = rand_bits(32);
            fwd.ex_store_data      = rand_bits(32);
            fwd.prev_ex_store_data = rand_bits(32);
            hazard             = '0;
            hazard.id_dst_addr = 5'd6;
            hazard.ex_dst_addr = 5'd6;
            case (k)
                0: hazard.alu2gpr_in_id_ex = 1'b1;
                1: hazard.alu2gpr_in_ex_mem = 1'b1;
                2: begin
                    hazard.load_in_id_ex         = 1'b1;
                    hazard.load_after_storing_en = 1'b1;
                end
                default: hazard.load_in_id_ex = 1'b1;   // load without store data
            endcase
            cpu_en = 1'b1;
            fetch_cycle();
            hazard = '0;
        end
        fetch_cycle();
        end_test("jalr forwarding", errs);
    endtask

    task automatic redirect_priority();
        int          errs;
        logic [31:0] r;
        errs = n_errors;
        for (int k = 0; k < 3; k++) begin
            write_imem(exp_pc[9:2], random_jal());
            r = rand_bits(30);
            redirect.taken = 1'b1;
            redirect.addr  = {r[29:0], 2'b00};
            r = rand_bits(30);
            trap_ctrl.trap_happened = (k == 1);
            trap_ctrl.mret_en       = (k == 2);
            trap_ctrl.ctrl_pc       = {r[29:0], 2'b00};
            pc_stall = (k == 2);    // mret goes through a stall
            cpu_en   = 1'b1;
            fetch_cycle();
        end
        trap_ctrl = '0;
        fetch_cycle();              // resolved branch under stall
        redirect = '0;
        pc_stall = 1'b0;
        fetch_cycle();
        end_test("redirect priority", errs);
    endtask

    initial begin
        clk       = 1'b0;
        rst_n     = 1'b0;
        cpu_en    = 1'b0;
        pc_stall  = 1'b0;
        redirect  = '0;
        trap_ctrl = '0;
        gpr_wr    = '0;
        hazard    = '0;
        fwd       = '0;
        imem_wr   = '0;
        n_checks  = 0;
        n_errors  = 0;
        exp_pc    = '0;
        for (int i = 0; i < 32; i++) begin
            ref_regs[i] = '0;
        end
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        reset_and_sequential();
        jal_and_branches();
        jalr_bases();
        jalr_forwarding();
        redirect_priority();
        $display("%0d checks, %0d mismatches", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    initial begin
        #(CYCLE_BUDGET * 2 * CLK_PERIOD);
        $display("watchdog expired after %0d cycles", CYCLE_BUDGET * 2);
        $display("TB FAILED");
        $finish;
    end

endmodule
